// File: rtl/axiLogPkg.sv
package axiLogPkg;

  // Widths of the logged address channel fields
  localparam int AxiIdWidth = 8;
  localparam int AxiAddrWidth = 32;
  localparam int AxiLenWidth = 8;

  // Free-running cycle counter stored with each entry
  localparam int TimestampWidth = 32;

  // Readout lanes, lane 0 is the lowest
  localparam int LaneWidth = 32;
  localparam int NumLanes = 3;
  localparam int EntryWidth = NumLanes * LaneWidth;

  // Log buffer geometry
  localparam int NumLogEntries = 256;
  localparam int LogCntWidth = $clog2(NumLogEntries);
  localparam int LogCntMax = NumLogEntries - 1;

  // Full flag rises this many entries before the end
  localparam int FullMargin = 64;

  // Entry index in the upper bits, lane in the lower two
  localparam int RdAddrWidth = LogCntWidth + 2;

  // One log word, seen as fields by the logger and as lanes by the readout
  typedef union packed {
    struct packed {
      logic [AxiAddrWidth-1:0] addr;
      logic [LaneWidth-AxiIdWidth-AxiLenWidth-1:0] metaPad;
      logic [AxiIdWidth-1:0] id;
      logic [AxiLenWidth-1:0] len;
      logic [TimestampWidth-1:0] timestamp;
    } fields;
    logic [NumLanes-1:0][LaneWidth-1:0] lanes;
  } logEntryT;

endpackage

// File: rtl/bramTdp.sv
`timescale 1ns/1ps

module bramTdp
  import axiLogPkg::*;
(
  input  logic                   Clk_CI,

  // Port A, write side used by the logger
  input  logic                   wrEnA,
  input  logic [LogCntWidth-1:0] wrAddrA,
  input  logEntryT               wrDataA,

  // Port B, read side used by the readout converter
  input  logic                   rdEnB,
  input  logic [LogCntWidth-1:0] rdAddrB,
  output logEntryT               rdDataB
);

  // One full entry per word
  logic [EntryWidth-1:0] mem [NumLogEntries];

  // Whole-entry write
  always_ff @(posedge Clk_CI) begin
    if (wrEnA) begin
      mem[wrAddrA] <= wrDataA;
    end
  end

  // Registered read, output holds between reads
  always_ff @(posedge Clk_CI) begin
    if (rdEnB) begin
      rdDataB <= mem[rdAddrB];
    end
  end

endmodule

// File: rtl/bramDwc.sv
`timescale 1ns/1ps

module bramDwc
  import axiLogPkg::*;
(
  input  logic                   Clk_CI,
  input  logic                   reset,

  // 32-bit readout port
  input  logic                   rdEn,
  input  logic [RdAddrWidth-1:0] rdAddr,
  output logic [LaneWidth-1:0]   rdData,

  // Entry-wide RAM port B
  output logic                   rdEnB,
  output logic [LogCntWidth-1:0] rdAddrB,
  input  logEntryT               rdDataB
);

  // Lane part of the word address
  logic [RdAddrWidth-LogCntWidth-1:0] laneIn;

  // Lane of the read in flight, aligned with the RAM output
  logic [RdAddrWidth-LogCntWidth-1:0] laneQ;

  // Upper bits pick the entry, lower bits the lane
  assign laneIn = rdAddr[RdAddrWidth-LogCntWidth-1:0];
  assign rdAddrB = rdAddr[RdAddrWidth-1:RdAddrWidth-LogCntWidth];

  // Every readout access is one RAM read
  assign rdEnB = rdEn;

  // Lane is kept only on a read so the output holds with the RAM data
  always_ff @(posedge Clk_CI) begin
    if (reset) begin
      laneQ <= '0;
    end else if (rdEn) begin
      laneQ <= laneIn;
    end
  end

  // Pick the lane from the returned entry
  // the unused fourth lane reads as zero
  always_comb begin
    rdData = '0;
    for (int i = 0; i < NumLanes; i++) begin
      if (laneQ == (RdAddrWidth - LogCntWidth)'(i)) begin
        rdData = rdDataB.lanes[i];
      end
    end
  end

endmodule

// File: rtl/axiBramLogger.sv
`timescale 1ns/1ps

module axiBramLogger
  import axiLogPkg::*;
(
  input  logic                    Clk_CI,
  input  logic                    reset,

  // Observed AXI address channel
  input  logic                    axiValid,
  input  logic                    axiReady,
  input  logic [AxiIdWidth-1:0]   axiId,
  input  logic [AxiAddrWidth-1:0] axiAddr,
  input  logic [AxiLenWidth-1:0]  axiLen,

  // Control and status
  input  logic                    clear,
  output logic                    full,

  // RAM port A
  output logic                    wrEnA,
  output logic [LogCntWidth-1:0]  wrAddrA,
  output logEntryT                wrDataA
);

  // FSM codes
  localparam logic [1:0] StReady = 2'd0;
  localparam logic [1:0] StClearing = 2'd1;
  localparam logic [1:0] StFull = 2'd2;

  logic [1:0] stateQ;
  logic [1:0] stateD;

  // Next entry to write, also the clearing address
  logic [LogCntWidth-1:0] wrCntQ;
  logic [LogCntWidth-1:0] wrCntD;

  logic [TimestampWidth-1:0] timestampQ;
  logic [TimestampWidth-1:0] timestampD;

  // Handshake on the address channel
  logic axiEvent;

  assign axiEvent = axiValid && axiReady;

  // Control FSM
  always_comb begin
    stateD = stateQ;
    wrCntD = wrCntQ;
    wrEnA = 1'b0;
    full = 1'b0;

    case (stateQ)
      StReady: begin
        // Events coinciding with clear are dropped
        if (axiEvent && !clear) begin
          wrEnA = 1'b1;
          wrCntD = wrCntQ + 1'b1;
        end
        // Early warning before the buffer ends
        if (wrCntQ >= LogCntWidth'(LogCntMax - FullMargin)) begin
          full = 1'b1;
        end
        // Last slot, an event here still lands at LogCntMax
        if (wrCntQ == LogCntWidth'(LogCntMax)) begin
          stateD = StFull;
        end
        // Empty log needs no clearing pass
        if (clear && wrCntQ != '0) begin
          wrCntD = '0;
          stateD = StClearing;
        end
      end

      StClearing: begin
        // One zero entry per cycle, clear and events ignored
        wrEnA = 1'b1;
        wrCntD = wrCntQ + 1'b1;
        if (wrCntQ == LogCntWidth'(LogCntMax)) begin
          wrCntD = '0;
          stateD = StReady;
        end
      end

      StFull: begin
        full = 1'b1;
        if (clear) begin
          wrCntD = '0;
          stateD = StClearing;
        end
      end

      default: begin
        wrCntD = '0;
        stateD = StReady;
      end
    endcase
  end

  assign wrAddrA = wrCntQ;

  // Entry formatting, zeros while clearing
  always_comb begin
    wrDataA = '0;
    if (stateQ != StClearing) begin
      wrDataA.fields.timestamp = timestampQ;
      wrDataA.fields.len = axiLen;
      wrDataA.fields.id = axiId;
      wrDataA.fields.addr = axiAddr;
    end
  end

  // Timestamp restarts on clear and during the clearing pass
  // and otherwise wraps naturally at all-ones
  always_comb begin
    if (clear || stateQ == StClearing) begin
      timestampD = '0;
    end else begin
      timestampD = timestampQ + 1'b1;
    end
  end

  always_ff @(posedge Clk_CI) begin
    if (reset) begin
      stateQ <= StReady;
      wrCntQ <= '0;
      timestampQ <= '0;
    end else begin
      stateQ <= stateD;
      wrCntQ <= wrCntD;
      timestampQ <= timestampD;
    end
  end

endmodule

// File: rtl/axiLoggerTop.sv
`timescale 1ns/1ps

module axiLoggerTop
  import axiLogPkg::*;
(
  input  logic                    Clk_CI,
  input  logic                    reset,

  // Observed AXI address channel
  input  logic                    axiValid,
  input  logic                    axiReady,
  input  logic [AxiIdWidth-1:0]   axiId,
  input  logic [AxiAddrWidth-1:0] axiAddr,
  input  logic [AxiLenWidth-1:0]  axiLen,

  // Control and status
  input  logic                    clear,
  output logic                    full,

  // Host readout
  input  logic                    rdEn,
  input  logic [RdAddrWidth-1:0]  rdAddr,
  output logic [LaneWidth-1:0]    rdData
);

  // Logger to RAM port A
  logic                   wrEnA;
  logic [LogCntWidth-1:0] wrAddrA;
  logEntryT               wrDataA;

  // Converter to RAM port B
  logic                   rdEnB;
  logic [LogCntWidth-1:0] rdAddrB;
  logEntryT               rdDataB;

  axiBramLogger u_axiBramLogger (
    .Clk_CI   (Clk_CI),
    .reset    (reset),
    .axiValid (axiValid),
    .axiReady (axiReady),
    .axiId    (axiId),
    .axiAddr  (axiAddr),
    .axiLen   (axiLen),
    .clear    (clear),
    .full     (full),
    .wrEnA    (wrEnA),
    .wrAddrA  (wrAddrA),
    .wrDataA  (wrDataA)
  );

  bramTdp u_bramTdp (
    .Clk_CI  (Clk_CI),
    .wrEnA   (wrEnA),
    .wrAddrA (wrAddrA),
    .wrDataA (wrDataA),
    .rdEnB   (rdEnB),
    .rdAddrB (rdAddrB),
    .rdDataB (rdDataB)
  );

  bramDwc u_bramDwc (
    .Clk_CI  (Clk_CI),
    .reset   (reset),
    .rdEn    (rdEn),
    .rdAddr  (rdAddr),
    .rdData  (rdData),
    .rdEnB   (rdEnB),
    .rdAddrB (rdAddrB),
    .rdDataB (rdDataB)
  );

endmodule

// File: testbench/tbLogger.sv
`timescale 1ns/1ps

module tbLogger
  import axiLogPkg::*;
;

  localparam int ClkPeriod = 40;
  localparam int WatchdogCycles = NumLogEntries * 8;

  // Model state codes
  localparam int ModelReady = 0;
  localparam int ModelClearing = 1;
  localparam int ModelFull = 2;

  logic                    Clk_CI;
  logic                    reset;
  logic                    axiValid;
  logic                    axiReady;
  logic [AxiIdWidth-1:0]   axiId;
  logic [AxiAddrWidth-1:0] axiAddr;
  logic [AxiLenWidth-1:0]  axiLen;
  logic                    clear;
  logic                    full;
  logic                    rdEn;
  logic [RdAddrWidth-1:0]  rdAddr;
  logic [LaneWidth-1:0]    rdData;

  integer seed;
  int errorCount;

  // Reference log model
  int modelState;
  int wrIdx;
  logic [31:0] cycleCnt;
  logic [31:0] tsZeroCycle;
  logic [LaneWidth-1:0] expTs [NumLogEntries];
  logic [LaneWidth-1:0] expMeta [NumLogEntries];
  logic [LaneWidth-1:0] expAddr [NumLogEntries];
  logic [31:0] evCycle [NumLogEntries];
  logic [31:0] evZero [NumLogEntries];
  logic [LaneWidth-1:0] readTs [NumLogEntries];
  logic expFull;

  axiLoggerTop u_axiLoggerTop (
    .Clk_CI   (Clk_CI),
    .reset    (reset),
    .axiValid (axiValid),
    .axiReady (axiReady),
    .axiId    (axiId),
    .axiAddr  (axiAddr),
    .axiLen   (axiLen),
    .clear    (clear),
    .full     (full),
    .rdEn     (rdEn),
    .rdAddr   (rdAddr),
    .rdData   (rdData)
  );

  initial begin
    Clk_CI = 1'b0;
    forever #(ClkPeriod / 2) Clk_CI = ~Clk_CI;
  end

  // Early warning in Ready, always set in Full, never while clearing
  assign expFull = (modelState == ModelFull) ||
                   (modelState == ModelReady && wrIdx >= LogCntMax - FullMargin);

  // Model follows the logging rules on every rising edge
  always @(posedge Clk_CI) begin
    if (reset) begin
      modelState = ModelReady;
      wrIdx = 0;
      cycleCnt = '0;
      tsZeroCycle = '0;
    end else begin
      // Timestamp restarts in the cycle after a clear or a clearing cycle
      if (clear || modelState == ModelClearing) begin
        tsZeroCycle = cycleCnt + 1;
      end else if (modelState == ModelReady && axiValid && axiReady) begin
        expTs[wrIdx] = cycleCnt - tsZeroCycle;
        expMeta[wrIdx] = {16'h0, axiId, axiLen};
        expAddr[wrIdx] = axiAddr;
        evCycle[wrIdx] = cycleCnt;
        evZero[wrIdx] = tsZeroCycle;
      end
      case (modelState)
        ModelReady: begin
          if (wrIdx == LogCntMax) begin
            modelState = ModelFull;
          end
          if (clear && wrIdx != 0) begin
            modelState = ModelClearing;
            wrIdx = 0;
          end else if (axiValid && axiReady && !clear) begin
            wrIdx = (wrIdx + 1) % NumLogEntries;
          end
        end
        ModelClearing: begin
          expTs[wrIdx] = '0;
          expMeta[wrIdx] = '0;
          expAddr[wrIdx] = '0;
          if (wrIdx == LogCntMax) begin
            modelState = ModelReady;
            wrIdx = 0;
          end else begin
            wrIdx = wrIdx + 1;
          end
        end
        default: begin
          if (clear) begin
            modelState = ModelClearing;
            wrIdx = 0;
          end
        end
      endcase
      cycleCnt = cycleCnt + 1;
    end
  end

  // Full flag checked away from the active edge
  assert property (@(negedge Clk_CI) disable iff (reset) full == expFull)
    else begin
      $display("mismatch at %0t: full is %0b, expected %0b", $time, full, expFull);
      errorCount++;
    end

  function automatic logic [LaneWidth-1:0] expLane(input int entry, input int lane);
    logic [LaneWidth-1:0] val;
    case (lane)
      0: val = expTs[entry];
      1: val = expMeta[entry];
      2: val = expAddr[entry];
      default: val = '0;
    endcase
    return val;
  endfunction

  // One readout access, data checked a cycle later
  task automatic readLane(input int entry, input int lane, output logic [LaneWidth-1:0] got);
    logic [LaneWidth-1:0] expData;
    expData = expLane(entry, lane);
    rdEn = 1'b1;
    rdAddr = RdAddrWidth'(entry * 4 + lane);
    @(negedge Clk_CI);
    rdEn = 1'b0;
    got = rdData;
    assert (rdData === expData)
      else begin
        $display("mismatch at %0t: entry %0d lane %0d read %h, expected %h",
                 $time, entry, lane, rdData, expData);
        errorCount++;
      end
  endtask

  task automatic readEntry(input int entry);
    logic [LaneWidth-1:0] got;
    for (int lane = 0; lane < 4; lane++) begin
      readLane(entry, lane, got);
    end
  endtask

  task automatic idleBus();
    axiValid = 1'b0;
    axiReady = 1'b0;
  endtask

  task automatic driveRandomFields();
    logic [31:0] rnd;
    rnd = $random(seed);
    axiId = rnd[AxiIdWidth-1:0];
    axiLen = rnd[15:8];
    rnd = $random(seed);
    axiAddr = rnd;
  endtask

  // Single handshake with given field values
  task automatic logEvent(input logic [7:0] id, input logic [31:0] addr, input logic [7:0] len);
    axiValid = 1'b1;
    axiReady = 1'b1;
    axiId = id;
    axiAddr = addr;
    axiLen = len;
    @(negedge Clk_CI);
    idleBus();
  endtask

  // Clearing length is fixed at one entry per cycle
  task automatic runClear();
    clear = 1'b1;
    @(negedge Clk_CI);
    clear = 1'b0;
    repeat (NumLogEntries) @(negedge Clk_CI);
  endtask

  task automatic randomTraffic(input int numCycles);
    logic [31:0] rnd;
    for (int i = 0; i < numCycles; i++) begin
      rnd = $random(seed);
      axiValid = rnd[0];
      axiReady = rnd[1];
      driveRandomFields();
      @(negedge Clk_CI);
    end
    idleBus();
  endtask

  // Back-to-back events until the log reports Full
  task automatic fillUntilFull();
    int guard;
    guard = 0;
    while (modelState != ModelFull && guard < 2 * NumLogEntries) begin
      axiValid = 1'b1;
      axiReady = 1'b1;
      driveRandomFields();
      @(negedge Clk_CI);
      guard++;
    end
    if (modelState != ModelFull) begin
      $display("Log never reached the full state while filling");
      errorCount++;
    end
    // These events must be dropped
    repeat (8) begin
      driveRandomFields();
      @(negedge Clk_CI);
    end
    idleBus();
  endtask

  // Spacing of stored timestamps against event cycles
  task automatic checkSpacing(input int numEntries);
    logic [31:0] expDiff;
    for (int i = 0; i < numEntries; i++) begin
      if (i == 0) begin
        expDiff = evCycle[0] - evZero[0];
        assert (readTs[0] == expDiff)
          else begin
            $display("mismatch at %0t: first timestamp %0d, expected %0d",
                     $time, readTs[0], expDiff);
            errorCount++;
          end
      end else begin
        expDiff = evCycle[i] - evCycle[i-1];
        assert (readTs[i] - readTs[i-1] == expDiff)
          else begin
            $display("mismatch at %0t: timestamp step at entry %0d, expected %0d",
                     $time, i, expDiff);
            errorCount++;
          end
      end
    end
  endtask

  initial begin
    logic [LaneWidth-1:0] got;
    int numLogged;
    seed = 32'hcc2064d8;
    errorCount = 0;
    reset = 1'b1;
    clear = 1'b0;
    rdEn = 1'b0;
    rdAddr = '0;
    axiId = '0;
    axiAddr = '0;
    axiLen = '0;
    idleBus();
    repeat (5) @(negedge Clk_CI);
    reset = 1'b0;
    @(negedge Clk_CI);

    // Log one entry so that the first clear walks the whole buffer
    logEvent(8'h01, 32'h0000_1000, 8'h00);
    runClear();
    readEntry(0);

    // Random handshakes, then read back every stored entry
    randomTraffic(48);
    numLogged = wrIdx;
    if (numLogged < 2) begin
      $display("Random traffic stored too few entries to check spacing");
      errorCount++;
    end
    for (int e = 0; e < numLogged; e++) begin
      readLane(e, 0, got);
      readTs[e] = got;
      readLane(e, 1, got);
      readLane(e, 2, got);
      readLane(e, 3, got);
    end
    checkSpacing(numLogged);

    // Read data holds while rdEn stays low, even with another address applied
    readLane(0, 2, got);
    rdAddr = RdAddrWidth'(1 * 4 + 1);
    @(negedge Clk_CI);
    assert (rdData === got)
      else begin
        $display("mismatch at %0t: readout changed to %h without a read", $time, rdData);
        errorCount++;
      end

    // Fill to the end, entry 0 must survive the dropped events
    fillUntilFull();
    readEntry(0);
    readEntry(LogCntMax - FullMargin);
    readEntry(LogCntMax);

    // Clear from Full zeroes the whole buffer
    runClear();
    readEntry(0);
    readEntry(1);
    readEntry(LogCntMax / 2);
    readEntry(LogCntMax);

    // Clear on an empty log only restarts the timestamp
    clear = 1'b1;
    @(negedge Clk_CI);
    clear = 1'b0;
    logEvent(8'h5a, 32'hdead_beef, 8'h0f);
    readEntry(0);
    readLane(0, 0, got);
    assert (got == '0)
      else begin
        $display("mismatch at %0t: timestamp after empty clear is %0d", $time, got);
        errorCount++;
      end
    readEntry(1);

    repeat (4) @(negedge Clk_CI);
    $display("Checks finished with %0d errors", errorCount);
    if (errorCount == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Watchdog sized well above the whole test sequence
  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("Timeout: test sequence did not finish within %0d cycles", WatchdogCycles);
    $display("Errors counted before the timeout: %0d", errorCount);
    $display("Test failures found");
    $finish;
  end

endmodule

// File: all.f
rtl/axiLogPkg.sv
rtl/bramTdp.sv
rtl/bramDwc.sv
rtl/axiBramLogger.sv
rtl/axiLoggerTop.sv
testbench/tbLogger.sv

// File: run.sh
#!/bin/sh
# Build and run the logger testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=simLogger

verilator --binary --timing --assert -Wno-fatal \
  --top-module tbLogger -f all.f -o "$BIN"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "All tests passed!" "$LOG"; then
  exit 0
else
  echo "Pass message not found in $LOG"
  exit 1
fi
